//--- hw/core_pkg.sv
package core_pkg;

    // data word width
    localparam int XLEN = 32;

    // architectural integer registers
    localparam int REG_COUNT = 32;

    // bits needed to name one register
    localparam int REG_IDX_W = $clog2(REG_COUNT);

    // raw immediate field width
    localparam int IMM_W = 12;

    // one data word
    typedef logic [XLEN-1:0] word_t;

    // register index
    typedef logic [REG_IDX_W-1:0] reg_idx_t;

    // immediate as it arrives on the issue port, sign-extended by ADDI
    typedef logic [IMM_W-1:0] imm_t;

    // alu operations
    // all but ADDI take rj and rk
    typedef enum logic [2:0] {
        ALU_ADD  = 3'd0,
        ALU_SUB  = 3'd1,
        ALU_AND  = 3'd2,
        ALU_OR   = 3'd3,
        ALU_XOR  = 3'd4,
        // signed less-than, result 0 or 1
        ALU_SLT  = 3'd5,
        // shift amount from low bits of rk
        ALU_SLL  = 3'd6,
        ALU_ADDI = 3'd7
    } alu_op_t;

endpackage

//--- hw/regfile.sv
`timescale 1ns/1ps

module regfile (
    input  logic               clk,
    input  logic               rst_i,
    // operand read ports
    input  core_pkg::reg_idx_t raddr1_i,
    input  core_pkg::reg_idx_t raddr2_i,
    output core_pkg::word_t    rdata1_o,
    output core_pkg::word_t    rdata2_o,
    // commit write port
    input  logic               we_i,
    input  core_pkg::reg_idx_t waddr_i,
    input  core_pkg::word_t    wdata_i
);

    core_pkg::word_t regs [core_pkg::REG_COUNT];

    // whole array cleared on reset
    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < core_pkg::REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (waddr_i != '0)) begin
            // r0 never written
            regs[waddr_i] <= wdata_i;
        end
    end

    // async read, r0 hardwired to zero
    // same-cycle write not forwarded here, the commit register covers it
    assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

endmodule

//--- hw/bypass_net.sv
`timescale 1ns/1ps

module bypass_net (
    input  core_pkg::reg_idx_t src1_i,
    input  core_pkg::reg_idx_t src2_i,
    input  core_pkg::word_t    rf_data1_i,
    input  core_pkg::word_t    rf_data2_i,
    // live alu result, youngest
    input  logic               ex_valid_i,
    input  core_pkg::reg_idx_t ex_rd_i,
    input  core_pkg::word_t    ex_data_i,
    // execute register
    input  logic               mem_valid_i,
    input  core_pkg::reg_idx_t mem_rd_i,
    input  core_pkg::word_t    mem_data_i,
    // commit register, oldest in flight
    input  logic               wb_valid_i,
    input  core_pkg::reg_idx_t wb_rd_i,
    input  core_pkg::word_t    wb_data_i,
    output core_pkg::word_t    op1_o,
    output core_pkg::word_t    op2_o
);

    // youngest matching producer wins
    function automatic core_pkg::word_t pick(
        input core_pkg::reg_idx_t src,
        input core_pkg::word_t    rf_data
    );
        core_pkg::word_t res;
        if (src == '0) begin
            res = '0;
        end else if (ex_valid_i && (ex_rd_i == src)) begin
            res = ex_data_i;
        end else if (mem_valid_i && (mem_rd_i == src)) begin
            res = mem_data_i;
        end else if (wb_valid_i && (wb_rd_i == src)) begin
            res = wb_data_i;
        end else begin
            res = rf_data;
        end
        return res;
    endfunction

    always_comb begin
        op1_o = pick(src1_i, rf_data1_i);
        op2_o = pick(src2_i, rf_data2_i);
    end

endmodule

//--- hw/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
    input  logic                clk,
    input  logic                rst_i,
    // issue port
    input  logic                inst_valid_i,
    output logic                inst_ready_o,
    input  core_pkg::alu_op_t   inst_op_i,
    input  core_pkg::reg_idx_t  inst_rd_i,
    input  core_pkg::reg_idx_t  inst_rj_i,
    input  core_pkg::reg_idx_t  inst_rk_i,
    input  core_pkg::imm_t      inst_imm_i,
    // operand read, through regfile and bypass net
    output core_pkg::reg_idx_t  src1_o,
    output core_pkg::reg_idx_t  src2_o,
    input  core_pkg::word_t     op1_i,
    input  core_pkg::word_t     op2_i,
    // to execute
    output logic                out_valid_o,
    input  logic                out_ready_i,
    output core_pkg::alu_op_t   out_op_o,
    output core_pkg::reg_idx_t  out_rd_o,
    output core_pkg::word_t     out_a_o,
    output core_pkg::word_t     out_b_o
);

    localparam int EXT_W = core_pkg::XLEN - core_pkg::IMM_W;

    logic               valid_q;
    core_pkg::alu_op_t  op_q;
    core_pkg::reg_idx_t rd_q;
    core_pkg::word_t    a_q;
    core_pkg::word_t    b_q;
    core_pkg::word_t    imm_ext;
    core_pkg::word_t    b_sel;
    logic               accept;

    // source indices straight from the issue fields
    assign src1_o = inst_rj_i;
    assign src2_o = inst_rk_i;

    // sign-extend immediate, ADDI takes it in place of rk
    assign imm_ext = {{EXT_W{inst_imm_i[core_pkg::IMM_W-1]}}, inst_imm_i};
    assign b_sel = (inst_op_i == core_pkg::ALU_ADDI) ? imm_ext : op2_i;

    // free slot, or current content moves on this cycle
    assign inst_ready_o = !valid_q || out_ready_i;
    assign accept = inst_valid_i && inst_ready_o;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            valid_q <= 1'b0;
            op_q    <= core_pkg::ALU_ADD;
            rd_q    <= '0;
            a_q     <= '0;
            b_q     <= '0;
        end else begin
            if (inst_ready_o) begin
                valid_q <= inst_valid_i;
            end
            // operands captured with bypassed values
            if (accept) begin
                op_q <= inst_op_i;
                rd_q <= inst_rd_i;
                a_q  <= op1_i;
                b_q  <= b_sel;
            end
        end
    end

    assign out_valid_o = valid_q;
    assign out_op_o    = op_q;
    assign out_rd_o    = rd_q;
    assign out_a_o     = a_q;
    assign out_b_o     = b_q;

endmodule

//--- hw/exe_stage.sv
`timescale 1ns/1ps

module exe_stage (
    input  logic               clk,
    input  logic               rst_i,
    // from decode register
    input  logic               in_valid_i,
    output logic               in_ready_o,
    input  core_pkg::alu_op_t  in_op_i,
    input  core_pkg::reg_idx_t in_rd_i,
    input  core_pkg::word_t    in_a_i,
    input  core_pkg::word_t    in_b_i,
    // live result, first bypass source
    output core_pkg::word_t    alu_res_o,
    // to write-back
    output logic               out_valid_o,
    input  logic               out_ready_i,
    output core_pkg::reg_idx_t out_rd_o,
    output core_pkg::word_t    out_data_o
);

    localparam int SHAMT_W = $clog2(core_pkg::XLEN);

    logic               valid_q;
    core_pkg::reg_idx_t rd_q;
    core_pkg::word_t    data_q;
    core_pkg::word_t    alu_res;

    // alu
    always_comb begin
        alu_res = '0;
        case (in_op_i)
            // b already holds the extended immediate for ADDI
            core_pkg::ALU_ADD,
            core_pkg::ALU_ADDI: alu_res = in_a_i + in_b_i;
            core_pkg::ALU_SUB:  alu_res = in_a_i - in_b_i;
            core_pkg::ALU_AND:  alu_res = in_a_i & in_b_i;
            core_pkg::ALU_OR:   alu_res = in_a_i | in_b_i;
            core_pkg::ALU_XOR:  alu_res = in_a_i ^ in_b_i;
            core_pkg::ALU_SLT:  alu_res = {31'd0, $signed(in_a_i) < $signed(in_b_i)};
            core_pkg::ALU_SLL:  alu_res = in_a_i << in_b_i[SHAMT_W-1:0];
            default:            alu_res = '0;
        endcase
    end

    assign alu_res_o = alu_res;

    assign in_ready_o = !valid_q || out_ready_i;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            valid_q <= 1'b0;
            rd_q    <= '0;
            data_q  <= '0;
        end else if (in_ready_o) begin
            valid_q <= in_valid_i;
            // result and rd move on together
            if (in_valid_i) begin
                rd_q   <= in_rd_i;
                data_q <= alu_res;
            end
        end
    end

    // registered pair, second bypass source
    assign out_valid_o = valid_q;
    assign out_rd_o    = rd_q;
    assign out_data_o  = data_q;

endmodule

//--- hw/wb_stage.sv
`timescale 1ns/1ps

module wb_stage (
    input  logic               clk,
    input  logic               rst_i,
    // from execute register
    input  logic               in_valid_i,
    output logic               in_ready_o,
    input  core_pkg::reg_idx_t in_rd_i,
    input  core_pkg::word_t    in_data_i,
    // commit port
    output logic               commit_valid_o,
    input  logic               commit_ready_i,
    output core_pkg::reg_idx_t commit_rd_o,
    output core_pkg::word_t    commit_data_o,
    // regfile write strobe
    output logic               rf_we_o
);

    logic               valid_q;
    core_pkg::reg_idx_t rd_q;
    core_pkg::word_t    data_q;

    // holds while the outside is not taking the commit
    assign in_ready_o = !valid_q || commit_ready_i;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            valid_q <= 1'b0;
            rd_q    <= '0;
            data_q  <= '0;
        end else if (in_ready_o) begin
            valid_q <= in_valid_i;
            if (in_valid_i) begin
                rd_q   <= in_rd_i;
                data_q <= in_data_i;
            end
        end
    end

    assign commit_valid_o = valid_q;
    assign commit_rd_o    = rd_q;
    assign commit_data_o  = data_q;

    // write on transfer, regfile drops rd 0
    assign rf_we_o = valid_q && commit_ready_i;

endmodule

//--- hw/core_top.sv
`timescale 1ns/1ps

module core_top (
    input  logic               clk,
    input  logic               rst_i,
    // issue port
    input  logic               inst_valid_i,
    output logic               inst_ready_o,
    input  core_pkg::alu_op_t  inst_op_i,
    input  core_pkg::reg_idx_t inst_rd_i,
    input  core_pkg::reg_idx_t inst_rj_i,
    input  core_pkg::reg_idx_t inst_rk_i,
    input  core_pkg::imm_t     inst_imm_i,
    // commit port
    output logic               commit_valid_o,
    input  logic               commit_ready_i,
    output core_pkg::reg_idx_t commit_rd_o,
    output core_pkg::word_t    commit_data_o
);

    // operand read
    core_pkg::reg_idx_t src1;
    core_pkg::reg_idx_t src2;
    core_pkg::word_t    rf_data1;
    core_pkg::word_t    rf_data2;
    core_pkg::word_t    op1;
    core_pkg::word_t    op2;

    // decode to execute
    logic               dec_valid;
    logic               dec_ready;
    core_pkg::alu_op_t  dec_op;
    core_pkg::reg_idx_t dec_rd;
    core_pkg::word_t    dec_a;
    core_pkg::word_t    dec_b;
    core_pkg::word_t    alu_res;

    // execute to write-back
    logic               exe_valid;
    logic               exe_ready;
    core_pkg::reg_idx_t exe_rd;
    core_pkg::word_t    exe_data;
    logic               rf_we;

    decode_stage u_decode (
        .clk, .rst_i,
        .inst_valid_i, .inst_ready_o, .inst_op_i, .inst_rd_i,
        .inst_rj_i, .inst_rk_i, .inst_imm_i,
        .src1_o(src1), .src2_o(src2), .op1_i(op1), .op2_i(op2),
        .out_valid_o(dec_valid), .out_ready_i(dec_ready), .out_op_o(dec_op),
        .out_rd_o(dec_rd), .out_a_o(dec_a), .out_b_o(dec_b)
    );

    regfile u_regfile (
        .clk, .rst_i,
        .raddr1_i(src1), .raddr2_i(src2), .rdata1_o(rf_data1), .rdata2_o(rf_data2),
        // written from the commit outputs
        .we_i(rf_we), .waddr_i(commit_rd_o), .wdata_i(commit_data_o)
    );

    // ex source is the instruction sitting in the decode register
    bypass_net u_bypass (
        .src1_i(src1), .src2_i(src2), .rf_data1_i(rf_data1), .rf_data2_i(rf_data2),
        .ex_valid_i(dec_valid), .ex_rd_i(dec_rd), .ex_data_i(alu_res),
        .mem_valid_i(exe_valid), .mem_rd_i(exe_rd), .mem_data_i(exe_data),
        .wb_valid_i(commit_valid_o), .wb_rd_i(commit_rd_o), .wb_data_i(commit_data_o),
        .op1_o(op1), .op2_o(op2)
    );

    exe_stage u_exe (
        .clk, .rst_i,
        .in_valid_i(dec_valid), .in_ready_o(dec_ready), .in_op_i(dec_op),
        .in_rd_i(dec_rd), .in_a_i(dec_a), .in_b_i(dec_b), .alu_res_o(alu_res),
        .out_valid_o(exe_valid), .out_ready_i(exe_ready),
        .out_rd_o(exe_rd), .out_data_o(exe_data)
    );

    wb_stage u_wb (
        .clk, .rst_i,
        .in_valid_i(exe_valid), .in_ready_o(exe_ready),
        .in_rd_i(exe_rd), .in_data_i(exe_data),
        .commit_valid_o, .commit_ready_i, .commit_rd_o, .commit_data_o,
        .rf_we_o(rf_we)
    );

endmodule

//--- test/tb_top.sv
`timescale 1ns/1ps

module tb_top;

    localparam int CLK_PERIOD = 100;
    // addi, setup, ops, chain, r0, stall, latency
    localparam int N_INST = 16 + 31 + 32 + 40 + 16 + 40 + 1;

    logic               clk = 1'b0;
    logic               rst_i = 1'b1;
    logic               inst_valid_i = 1'b0;
    logic               inst_ready_o;
    core_pkg::alu_op_t  inst_op_i = core_pkg::ALU_ADD;
    core_pkg::reg_idx_t inst_rd_i = '0;
    core_pkg::reg_idx_t inst_rj_i = '0;
    core_pkg::reg_idx_t inst_rk_i = '0;
    core_pkg::imm_t     inst_imm_i = '0;
    logic               commit_valid_o;
    logic               commit_ready_i = 1'b1;
    core_pkg::reg_idx_t commit_rd_o;
    core_pkg::word_t    commit_data_o;

    // in-order model state and expected commits
    core_pkg::word_t    model_rf [core_pkg::REG_COUNT];
    core_pkg::reg_idx_t exp_rd_q [$];
    core_pkg::word_t    exp_data_q [$];
    core_pkg::reg_idx_t hist [3];
    int                 n_issued = 0;
    int                 n_commit = 0;
    int                 n_stall = 0;
    bit                 gaps_on = 1'b0;
    // 0 always ready, 1 random, 2 long stalls
    logic [1:0]         ready_mode = 2'd0;
    int unsigned        low_left = 0;

    core_top dut_i (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic abort_run();
        $display("Something failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_rd(input string name, input core_pkg::reg_idx_t got,
                            input core_pkg::reg_idx_t exp);
        if (got !== exp) begin
            $display("ERR %s got 0x%h expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_data(input string name, input core_pkg::word_t got,
                              input core_pkg::word_t exp);
        if (got !== exp) begin
            $display("ERR %s got 0x%h expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERR %s got 0x%h expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    // op rules, straight from the ISA description
    function automatic core_pkg::word_t ref_alu(input core_pkg::alu_op_t op,
                                                input core_pkg::word_t a,
                                                input core_pkg::word_t b,
                                                input core_pkg::imm_t imm);
        core_pkg::word_t r;
        case (op)
            core_pkg::ALU_ADD:  r = a + b;
            core_pkg::ALU_SUB:  r = a - b;
            core_pkg::ALU_AND:  r = a & b;
            core_pkg::ALU_OR:   r = a | b;
            core_pkg::ALU_XOR:  r = a ^ b;
            core_pkg::ALU_SLT:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            core_pkg::ALU_SLL:  r = a << b[4:0];
            core_pkg::ALU_ADDI: r = a + {{20{imm[11]}}, imm};
            default:            r = '0;
        endcase
        return r;
    endfunction

    function automatic core_pkg::reg_idx_t rand_reg();
        return core_pkg::reg_idx_t'($urandom_range(1, 31));
    endfunction

    function automatic core_pkg::alu_op_t rand_op();
        logic [2:0] k;
        k = 3'($urandom_range(0, 7));
        return core_pkg::alu_op_t'(k);
    endfunction

    // model runs at issue, fields held until the core takes them
    task automatic issue(input core_pkg::alu_op_t op, input core_pkg::reg_idx_t rd,
                         input core_pkg::reg_idx_t rj, input core_pkg::reg_idx_t rk,
                         input core_pkg::imm_t imm);
        core_pkg::word_t res;
        int unsigned     gap;
        res = ref_alu(op, model_rf[rj], model_rf[rk], imm);
        exp_rd_q.push_back(rd);
        exp_data_q.push_back(res);
        // r0 in the model never changes
        if (rd != '0) begin
            model_rf[rd] = res;
        end
        gap = gaps_on ? $urandom_range(0, 2) : 0;
        @(negedge clk);
        repeat (gap) begin
            inst_valid_i = 1'b0;
            @(negedge clk);
        end
        inst_valid_i = 1'b1;
        inst_op_i = op;
        inst_rd_i = rd;
        inst_rj_i = rj;
        inst_rk_i = rk;
        inst_imm_i = imm;
        @(posedge clk);
        while (!inst_ready_o) begin
            @(posedge clk);
        end
        n_issued++;
    endtask

    // each source is the rd one, then two or three, back
    task automatic run_chain(input int count);
        core_pkg::reg_idx_t rd;
        for (int i = 0; i < count; i++) begin
            rd = rand_reg();
            issue(rand_op(), rd, hist[0], hist[1 + (i % 2)], core_pkg::imm_t'($urandom()));
            hist[2] = hist[1];
            hist[1] = hist[0];
            hist[0] = rd;
        end
    endtask

    task automatic drain();
        @(negedge clk);
        inst_valid_i = 1'b0;
        while (exp_rd_q.size() != 0) begin
            @(negedge clk);
        end
    endtask

    // commit side back-pressure
    always @(negedge clk) begin
        if (ready_mode == 2'd0) begin
            commit_ready_i = 1'b1;
        end else if (ready_mode == 2'd1) begin
            commit_ready_i = ($urandom_range(0, 3) != 0);
        end else if (low_left > 0) begin
            commit_ready_i = 1'b0;
            low_left = low_left - 1;
        end else begin
            // one open cycle, then the next long stall
            commit_ready_i = 1'b1;
            low_left = $urandom_range(8, 15);
        end
    end

    // commit checker, pops one expectation per transfer
    always @(posedge clk) begin
        if (!rst_i && !inst_ready_o) begin
            n_stall++;
        end
        if (!rst_i && commit_valid_o && commit_ready_i) begin
            if (exp_rd_q.size() == 0) begin
                $display("a commit arrived with no instruction pending");
                abort_run();
            end else begin
                check_rd("commit_rd_o", commit_rd_o, exp_rd_q.pop_front());
                check_data("commit_data_o", commit_data_o, exp_data_q.pop_front());
                n_commit++;
            end
        end
    end

    // budget of 20 cycles per instruction plus reset
    initial begin
        #((N_INST * 20 + 10) * CLK_PERIOD);
        $display("timeout, the instructions did not all commit in time");
        abort_run();
    end

    initial begin
        core_pkg::imm_t imm;
        int             stall_start;
        int             lat;
        void'($urandom(32'h82b542ed));
        for (int i = 0; i < core_pkg::REG_COUNT; i++) begin
            model_rf[i] = '0;
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_i = 1'b0;
        @(negedge clk);
        check_flag("commit_valid_o", commit_valid_o, 1'b0);
        check_flag("inst_ready_o", inst_ready_o, 1'b1);
        // addi from r0, every other immediate negative
        gaps_on = 1'b1;
        for (int i = 0; i < 16; i++) begin
            imm = core_pkg::imm_t'($urandom());
            imm[11] = i[0];
            issue(core_pkg::ALU_ADDI, rand_reg(), '0, '0, imm);
        end
        // random values in every register, then all eight ops
        ready_mode = 2'd1;
        for (int r = 1; r < 32; r++) begin
            issue(core_pkg::ALU_ADDI, core_pkg::reg_idx_t'(r), '0, '0,
                  core_pkg::imm_t'($urandom()));
        end
        for (int k = 0; k < 32; k++) begin
            issue(core_pkg::alu_op_t'(3'(k / 4)), rand_reg(), rand_reg(), rand_reg(),
                  core_pkg::imm_t'($urandom()));
        end
        hist[0] = 5'd1;
        hist[1] = 5'd2;
        hist[2] = 5'd3;
        run_chain(40);
        // r0 written, then read right behind the write
        for (int i = 0; i < 8; i++) begin
            issue(core_pkg::ALU_ADDI, '0, rand_reg(), '0, core_pkg::imm_t'($urandom()));
            issue(rand_op(), rand_reg(), '0, i[0] ? 5'd0 : rand_reg(),
                  core_pkg::imm_t'($urandom()));
        end
        // long commit stalls, issue as fast as allowed
        gaps_on = 1'b0;
        ready_mode = 2'd2;
        stall_start = n_stall;
        run_chain(40);
        if (n_stall == stall_start) begin
            $display("inst_ready_o never fell while commits were stalled");
            abort_run();
        end
        // one instruction into an empty pipeline
        ready_mode = 2'd0;
        drain();
        issue(core_pkg::ALU_ADDI, 5'd7, 5'd7, '0, 12'h123);
        // the acceptance edge is edge 1
        lat = 1;
        @(negedge clk);
        inst_valid_i = 1'b0;
        while (!commit_valid_o) begin
            lat++;
            @(negedge clk);
        end
        if (lat != 3) begin
            $display("commit_valid_o rose after edge %0d counted from acceptance, not edge 3",
                     lat);
            abort_run();
        end
        drain();
        if (n_commit == N_INST && n_issued == N_INST) begin
            $display("Everything OK");
            $finish;
        end else begin
            $display("issued %0d and committed %0d of %0d instructions",
                     n_issued, n_commit, N_INST);
            abort_run();
        end
    end

endmodule

//--- tb.f
hw/core_pkg.sv
hw/regfile.sv
hw/bypass_net.sv
hw/decode_stage.sv
hw/exe_stage.sv
hw/wb_stage.sv
hw/core_top.sv
test/tb_top.sv

//--- run.sh
#!/bin/sh
# build and run with Verilator, result decided from the log
verilator --binary --timing -f tb.f --top-module tb_top -o tb_sim || exit 1
./obj_dir/tb_sim > sim.log 2>&1 || true
cat sim.log
grep -q "Something failed" sim.log && exit 1 || grep -q "Everything OK" sim.log
